// ==== build.f ====
+incdir+include
hw/icache_pkg.sv
hw/sp_bram.sv
hw/plru_tree.sv
hw/credit_fifo.sv
hw/icache.sv
hw/icache_subsys.sv
tb/icache_checker.sv
tb/tb_icache_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_icache_subsys -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_icache_subsys)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

// ==== tb/tb_icache_subsys.sv ====
/* Testbench for the instruction cache subsystem. Applies a table of lookups and
   flushes, models the lower memory with credits and random latency, and checks
   every response against a reference model of tags and pseudo-LRU trees. */
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache_subsys
  import icache_pkg::*;
;

  localparam int NUM_SET   = `ICACHE_NUM_SET;
  localparam int NUM_WAY   = `ICACHE_NUM_WAY;
  localparam int DEPTH     = `ICACHE_FIFO_DEPTH;
  localparam int WORST_CYC = 100;
  localparam int NUM_VEC   = 22;

  typedef struct packed {
    logic [31:0] addr;
    logic        flush;
    logic        miss;
  } vec_t;

  // Address, flush before the lookup, expected miss
  localparam vec_t VECS [NUM_VEC] = '{
    '{32'h0000_0100, 1'b0, 1'b1}, '{32'h0000_0100, 1'b0, 1'b0},
    '{32'h0000_0108, 1'b0, 1'b0}, '{32'h0000_020C, 1'b0, 1'b1},
    '{32'h0000_0204, 1'b0, 1'b0},
    // Five blocks in set 5
    '{32'h0000_1050, 1'b0, 1'b1}, '{32'h0000_2050, 1'b0, 1'b1},
    '{32'h0000_3050, 1'b0, 1'b1}, '{32'h0000_4050, 1'b0, 1'b1},
    '{32'h0000_1054, 1'b0, 1'b0}, '{32'h0000_5050, 1'b0, 1'b1},
    '{32'h0000_2058, 1'b0, 1'b1}, '{32'h0000_105C, 1'b0, 1'b0},
    '{32'h0000_0100, 1'b1, 1'b1}, '{32'h0000_0100, 1'b0, 1'b0},
    // Back-to-back misses under slow memory
    '{32'h0000_0300, 1'b0, 1'b1}, '{32'h0000_0404, 1'b0, 1'b1},
    '{32'h0000_0508, 1'b0, 1'b1}, '{32'h0000_060C, 1'b0, 1'b1},
    '{32'h0000_0700, 1'b0, 1'b1}, '{32'h0000_0100, 1'b0, 1'b1},
    '{32'h0000_0704, 1'b0, 1'b0}
  };

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     flush_i;
  cpu_req_t cpu_req_i;
  logic     req_ready_o;
  cpu_res_t cpu_res_o;
  mem_req_t mem_req_o;
  logic     mem_req_credit_i;
  mem_res_t mem_res_i;
  logic     mem_res_credit_o;

  int          err_data;
  int          err_proto;
  logic [31:0] lfsr_q = 32'd75317;
  mem_req_t    exp_req_q [$];

  // Reference model state
  logic [23:0] ref_tag [NUM_SET][NUM_WAY];
  logic        ref_val [NUM_SET][NUM_WAY];
  logic [2:0]  ref_tree [NUM_SET];

  always #10 clk_i = ~clk_i;

  icache_subsys UUT (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'hA300_0000;
    return s >> 1;
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic [31:0] rule_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [127:0] rule_block(input logic [31:0] base);
    logic [127:0] b;
    for (int k = 0; k < 4; k++) b[k*32 +: 32] = rule_word(base + 32'(4 * k));
    return b;
  endfunction

  task automatic ref_clear();
    for (int s = 0; s < NUM_SET; s++) begin
      ref_tree[s] = 3'b000;
      for (int w = 0; w < NUM_WAY; w++) ref_val[s][w] = 1'b0;
    end
  endtask

  // Looks up the model and updates it, returns 1 on a miss
  function automatic logic ref_lookup(input logic [31:0] addr);
    int          set;
    int          way;
    logic        miss;
    logic [2:0]  t;
    set  = int'(addr[7:4]);
    way  = -1;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (ref_val[set][w] && ref_tag[set][w] == addr[31:8]) way = w;
    end
    miss = (way < 0);
    t    = ref_tree[set];
    if (miss) begin
      // Root bit picks the half, then the half's own bit
      if (!t[0]) way = t[1] ? 1 : 0;
      else       way = t[2] ? 3 : 2;
      ref_val[set][way] = 1'b1;
      ref_tag[set][way] = addr[31:8];
    end
    t[0] = (way < 2);
    if (way < 2) t[1] = (way == 0);
    else         t[2] = (way == 2);
    ref_tree[set] = t;
    return miss;
  endfunction

  task automatic check_res(input cpu_res_t got, input cpu_res_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: response miss=%0b data=%h, expected miss=%0b data=%h",
               $time, got.miss, got.data, exp.miss, exp.data);
      err_data++;
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: memory request addr=%h, expected addr=%h",
               $time, got.addr, exp.addr);
      err_data++;
    end
  endtask

  // Memory model, decides on the falling edge, drives on the rising edge
  logic [31:0] pend_addr [$];
  int          pend_time [$];
  int          cred_time [$];
  int          rsp_credits;
  int          cyc;
  mem_res_t    nxt_res = '0;
  logic        nxt_credit = 1'b0;

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      pend_addr.delete();
      pend_time.delete();
      cred_time.delete();
      rsp_credits = DEPTH;
      cyc         = 0;
      nxt_res     = '0;
      nxt_credit  = 1'b0;
    end else begin
      cyc++;
      if (mem_res_credit_o) rsp_credits++;
      if (rsp_credits > DEPTH) begin
        $display("More response credits returned than responses sent at %0t", $time);
        err_proto++;
        rsp_credits = DEPTH;
      end
      if (mem_req_o.valid) begin
        if (exp_req_q.size() == 0) begin
          $display("Unexpected memory request for address %h at %0t", mem_req_o.addr, $time);
          err_proto++;
        end else begin
          check_mem_req(mem_req_o, exp_req_q.pop_front());
        end
        pend_addr.push_back(mem_req_o.addr);
        pend_time.push_back(cyc + 1 + rand_bits(5));
        // Credit goes back late now and then
        cred_time.push_back(cyc + rand_bits(4));
      end
      nxt_res = '0;
      if (pend_addr.size() != 0 && pend_time[0] <= cyc && rsp_credits > 0) begin
        nxt_res.valid = 1'b1;
        nxt_res.blk   = rule_block(pend_addr.pop_front());
        void'(pend_time.pop_front());
        rsp_credits--;
      end
      nxt_credit = 1'b0;
      if (cred_time.size() != 0 && cred_time[0] <= cyc) begin
        nxt_credit = 1'b1;
        void'(cred_time.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    mem_res_i        <= nxt_res;
    mem_req_credit_i <= nxt_credit;
  end

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!req_ready_o && n < WORST_CYC) begin
      @(negedge clk_i);
      n++;
    end
    if (!req_ready_o) begin
      $display("Cache never became ready at %0t", $time);
      err_proto++;
    end
  endtask

  task automatic do_flush();
    int low;
    low = 0;
    wait_ready();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    while (!req_ready_o && low < WORST_CYC) begin
      low++;
      @(negedge clk_i);
    end
    if (low < NUM_SET) begin
      $display("Ready came back after %0d cycles of the flush walk at %0t", low, $time);
      err_proto++;
    end
    ref_clear();
  endtask

  task automatic do_lookup(input vec_t v);
    cpu_res_t exp;
    logic     model_miss;
    int       n;
    model_miss = ref_lookup(v.addr);
    if (model_miss != v.miss) begin
      $display("Table and reference model disagree on the miss for %h", v.addr);
      err_proto++;
    end
    exp.valid = 1'b1;
    exp.miss  = model_miss;
    exp.data  = rule_word(v.addr);
    if (model_miss) exp_req_q.push_back(mem_req_t'{valid: 1'b1, addr: {v.addr[31:4], 4'h0}});
    wait_ready();
    @(posedge clk_i);
    cpu_req_i <= '{valid: 1'b1, addr: v.addr};
    @(posedge clk_i);
    cpu_req_i <= '{valid: 1'b0, addr: v.addr};
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cpu_res_o.valid && n < WORST_CYC);
    if (!cpu_res_o.valid) begin
      $display("No response for address %h at %0t", v.addr, $time);
      err_proto++;
    end else begin
      check_res(cpu_res_o, exp);
      if (!model_miss && n != 1) begin
        $display("Hit for %h answered after %0d cycles", v.addr, n);
        err_proto++;
      end
    end
  endtask

  initial begin
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    cpu_req_i        = '0;
    mem_req_credit_i = 1'b0;
    mem_res_i        = '0;
    err_data         = 0;
    err_proto        = 0;
    ref_clear();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_VEC; i++) begin
      if (VECS[i].flush) do_flush();
      do_lookup(VECS[i]);
    end
    repeat (WORST_CYC) @(negedge clk_i);
    if (exp_req_q.size() != 0) begin
      $display("%0d expected memory requests never appeared", exp_req_q.size());
      err_proto++;
    end
    $display("Errors: %0d value, %0d protocol", err_data, err_proto);
    if (err_data == 0 && err_proto == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table and the worst miss latency
  initial begin
    #(20 * (NUM_VEC + 4) * (WORST_CYC + NUM_SET));
    $display("Watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/icache_checker.sv ====
/* Protocol assertions for the cache subsystem, bound to icache_subsys.
   Tracks request credits, lookup handshakes and the flush walk. */
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_checker
  import icache_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     flush_i,
  input cpu_req_t cpu_req_i,
  input logic     req_ready_o,
  input cpu_res_t cpu_res_o,
  input mem_req_t mem_req_o,
  input logic     mem_req_credit_i
);

  localparam int DEPTH   = `ICACHE_FIFO_DEPTH;
  localparam int NUM_SET = `ICACHE_NUM_SET;

  int   credits_q;
  int   walk_q;
  logic pending_q;
  logic accept;

  assign accept = cpu_req_i.valid && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      credits_q <= DEPTH;
      walk_q    <= 0;
      pending_q <= 1'b0;
    end else begin
      credits_q <= credits_q - int'(mem_req_o.valid) + int'(mem_req_credit_i);
      if (accept) begin
        pending_q <= 1'b1;
      end else if (cpu_res_o.valid) begin
        pending_q <= 1'b0;
      end
      // Flush is only raised while the cache is idle
      if (flush_i) begin
        walk_q <= NUM_SET;
      end else if (walk_q != 0) begin
        walk_q <= walk_q - 1;
      end
    end
  end

  a_credit_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credits_q <= DEPTH) && (credits_q >= 0))
    else $error("request credit count out of range");

  a_credit_gate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.valid |-> (credits_q > 0))
    else $error("memory request sent without a credit");

  a_one_res: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !pending_q)
    else $error("lookup accepted before the previous one was answered");

  a_res_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_res_o.valid |-> pending_q)
    else $error("lookup response without an accepted request");

  a_flush_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (walk_q != 0) |-> !req_ready_o)
    else $error("ready raised during the flush walk");

endmodule

bind icache_subsys icache_checker u_checker (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .flush_i         (flush_i),
  .cpu_req_i       (cpu_req_i),
  .req_ready_o     (req_ready_o),
  .cpu_res_o       (cpu_res_o),
  .mem_req_o       (mem_req_o),
  .mem_req_credit_i(mem_req_credit_i)
);

`default_nettype wire

// ==== hw/icache_subsys.sv ====
/* Instruction cache with its request and response link FIFOs.
   Refill requests leave through req_fifo under memory credits, refills enter through rsp_fifo. */
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache_subsys
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  cpu_req_t cpu_req_i,
  output logic     req_ready_o,
  output cpu_res_t cpu_res_o,
  output mem_req_t mem_req_o,
  input  logic     mem_req_credit_i,
  input  mem_res_t mem_res_i,
  output logic     mem_res_credit_o
);

  mem_req_t cache_mem_req;
  mem_res_t cache_mem_res;
  logic     cache_res_pop;

  icache u_icache (
    .clk_i,
    .rst_ni,
    .flush_i,
    .cpu_req_i,
    .req_ready_o,
    .cpu_res_o,
    .mem_req_o    (cache_mem_req),
    .mem_res_i    (cache_mem_res),
    .mem_res_pop_o(cache_res_pop)
  );

  // Head leaves as soon as it is shown, gated by memory credits
  credit_fifo #(
    .payload_t(mem_req_t),
    .DEPTH    (`ICACHE_FIFO_DEPTH)
  ) req_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (cache_mem_req),
    .pop_i   (1'b1),
    .head_o  (mem_req_o),
    .credit_i(mem_req_credit_i),
    .credit_o()
  );

  // Each pop goes back to memory and also refills the local count
  credit_fifo #(
    .payload_t(mem_res_t),
    .DEPTH    (`ICACHE_FIFO_DEPTH)
  ) rsp_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (mem_res_i),
    .pop_i   (cache_res_pop),
    .head_o  (cache_mem_res),
    .credit_i(mem_res_credit_o),
    .credit_o(mem_res_credit_o)
  );

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
/* Set-associative read-only instruction cache with tree pseudo-LRU replacement.
   One lookup at a time, hits answer the cycle after acceptance, misses refill a
   block through the memory link. A walk clears every set after reset and on flush_i. */
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module icache
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  cpu_req_t cpu_req_i,
  output logic     req_ready_o,
  output cpu_res_t cpu_res_o,
  output mem_req_t mem_req_o,
  input  mem_res_t mem_res_i,
  output logic     mem_res_pop_o
);

  localparam int XLEN    = `ICACHE_XLEN;
  localparam int BLK_W   = `ICACHE_BLK_BITS;
  localparam int NUM_WAY = `ICACHE_NUM_WAY;
  localparam int NUM_SET = `ICACHE_NUM_SET;
  localparam int IDX_W   = `ICACHE_IDX_W;
  localparam int BOFF_W  = `ICACHE_BOFF_W;
  localparam int TAG_W   = `ICACHE_TAG_W;
  localparam int WOFF_W  = $clog2(BLK_W / XLEN);

  // Tag array entry, valid bit above the tag
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  cpu_req_t                      req_q;
  logic                          miss_sent_q;
  logic                          flush_q;
  logic [IDX_W-1:0]              flush_idx_q;

  logic [TAG_W-1:0]              req_tag;
  logic [IDX_W-1:0]              req_idx;
  logic [WOFF_W-1:0]             word_idx;
  logic [IDX_W-1:0]              arr_idx;
  tag_entry_t [NUM_WAY-1:0]      tag_rd;
  tag_entry_t                    tag_wr;
  logic [NUM_WAY-1:0]            tag_we;
  logic [NUM_WAY-1:0][BLK_W-1:0] data_rd;
  logic [NUM_WAY-1:0]            data_we;
  logic [NUM_WAY-2:0]            node_rd;
  logic [NUM_WAY-2:0]            node_upd;
  logic [NUM_WAY-2:0]            node_wr;
  logic                          node_we;
  logic [NUM_WAY-1:0]            hit_vec;
  logic [NUM_WAY-1:0]            victim_way;
  logic [NUM_WAY-1:0]            access_way;
  logic [BLK_W-1:0]              hit_blk;
  logic [BLK_W-1:0]              res_blk;
  logic                          idle;
  logic                          accept;
  logic                          lookup_hit;
  logic                          lookup_miss;
  logic                          refill;

  assign req_tag  = req_q.addr[XLEN-1 -: TAG_W];
  assign req_idx  = req_q.addr[BOFF_W +: IDX_W];
  assign word_idx = req_q.addr[BOFF_W-1 -: WOFF_W];

  // Ready only with no walk, no lookup in flight and no flush pending
  assign idle        = !flush_q && !req_q.valid;
  assign req_ready_o = idle && !flush_i;
  assign accept      = cpu_req_i.valid && req_ready_o;

  // The index is held on the registered request until it completes
  always_comb begin
    if (flush_q) begin
      arr_idx = flush_idx_q;
    end else if (req_q.valid) begin
      arr_idx = req_idx;
    end else begin
      arr_idx = cpu_req_i.addr[BOFF_W +: IDX_W];
    end
  end

  // Tag compare across the ways
  always_comb begin
    hit_blk = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
      if (hit_vec[w]) hit_blk = hit_blk | data_rd[w];
    end
  end

  assign lookup_hit    = req_q.valid && !miss_sent_q && (|hit_vec);
  assign lookup_miss   = req_q.valid && !miss_sent_q && !(|hit_vec);
  assign refill        = miss_sent_q && mem_res_i.valid;
  assign mem_res_pop_o = refill;

  // One block request per miss, pushed in the first lookup cycle
  always_comb begin
    mem_req_o.valid = lookup_miss;
    mem_req_o.addr  = {req_q.addr[XLEN-1:BOFF_W], {BOFF_W{1'b0}}};
  end

  // Refill data bypasses the arrays in the pop cycle
  assign res_blk = refill ? mem_res_i.blk : hit_blk;

  always_comb begin
    cpu_res_o.valid = lookup_hit || refill;
    cpu_res_o.miss  = refill;
    cpu_res_o.data  = res_blk[word_idx*XLEN +: XLEN];
  end

  assign access_way = refill ? victim_way : hit_vec;

  // Array writes, the walk forces zeros into tags and tree
  always_comb begin
    tag_wr.valid = !flush_q;
    tag_wr.tag   = flush_q ? '0 : req_tag;
    node_wr      = flush_q ? '0 : node_upd;
    node_we      = flush_q || lookup_hit || refill;
    for (int w = 0; w < NUM_WAY; w++) begin
      tag_we[w]  = flush_q || (refill && victim_way[w]);
      data_we[w] = refill && victim_way[w];
    end
  end

  // Flush walk, one set per cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      flush_q     <= 1'b1;
      flush_idx_q <= '0;
    end else if (flush_q) begin
      if (flush_idx_q == IDX_W'(NUM_SET - 1)) begin
        flush_q     <= 1'b0;
        flush_idx_q <= '0;
      end else begin
        flush_idx_q <= flush_idx_q + 1'b1;
      end
    end else if (idle && flush_i) begin
      flush_q <= 1'b1;
    end
  end

  // Request register and miss tracking
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_q       <= '0;
      miss_sent_q <= 1'b0;
    end else begin
      if (accept) begin
        req_q <= cpu_req_i;
      end else if (lookup_hit || refill) begin
        req_q.valid <= 1'b0;
      end
      if (lookup_miss) begin
        miss_sent_q <= 1'b1;
      end else if (refill) begin
        miss_sent_q <= 1'b0;
      end
    end
  end

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    sp_bram #(
      .DATA_W($bits(tag_entry_t)),
      .DEPTH (NUM_SET)
    ) tag_ram (
      .clk_i,
      .addr_i   (arr_idx),
      .wr_en_i  (tag_we[w]),
      .wr_data_i(tag_wr),
      .rd_data_o(tag_rd[w])
    );

    sp_bram #(
      .DATA_W(BLK_W),
      .DEPTH (NUM_SET)
    ) data_ram (
      .clk_i,
      .addr_i   (arr_idx),
      .wr_en_i  (data_we[w]),
      .wr_data_i(mem_res_i.blk),
      .rd_data_o(data_rd[w])
    );
  end

  sp_bram #(
    .DATA_W(NUM_WAY - 1),
    .DEPTH (NUM_SET)
  ) tree_ram (
    .clk_i,
    .addr_i   (arr_idx),
    .wr_en_i  (node_we),
    .wr_data_i(node_wr),
    .rd_data_o(node_rd)
  );

  plru_tree #(
    .NUM_WAY(NUM_WAY)
  ) u_plru (
    .node_i      (node_rd),
    .access_way_i(access_way),
    .victim_way_o(victim_way),
    .node_o      (node_upd)
  );

endmodule

`default_nettype wire

// ==== hw/credit_fifo.sv ====
/* Circular FIFO of struct payloads for the memory-side links. The head is shown
   only while the credit count is non-zero and leaves on pop_i. credit_o pulses
   once per entry popped and credit_i returns one credit to the counter. */
`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module credit_fifo
  import icache_pkg::*;
#(
  parameter type payload_t = mem_req_t,
  parameter int  DEPTH     = `ICACHE_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t push_i,
  input  logic     pop_i,
  output payload_t head_o,
  input  logic     credit_i,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic [CNT_W-1:0] credit_cnt_q;
  logic             push;
  logic             send;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign push = push_i.valid && (fill_q != CNT_W'(DEPTH));

  // Head valid needs a stored entry and a credit from the receiver
  always_comb begin
    head_o       = mem_q[rd_ptr_q];
    head_o.valid = (fill_q != '0) && (credit_cnt_q != '0);
  end

  assign send     = pop_i && head_o.valid;
  assign credit_o = send;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      fill_q       <= '0;
      credit_cnt_q <= CNT_W'(DEPTH);
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (send) rd_ptr_q <= next_ptr(rd_ptr_q);
      fill_q       <= fill_q + CNT_W'(push) - CNT_W'(send);
      // One credit spent per send, one back per credit pulse
      credit_cnt_q <= credit_cnt_q + CNT_W'(credit_i) - CNT_W'(send);
    end
  end

endmodule

`default_nettype wire

// ==== hw/plru_tree.sv ====
/* Tree pseudo-LRU for one set. Picks the victim way from the tree bits and
   gives the bits after an access. Node 0 is the root, node n has children 2n+1 and 2n+2. */
`timescale 1ns/10ps
`default_nettype none

module plru_tree #(
  parameter int NUM_WAY = 4
) (
  input  logic [NUM_WAY-2:0] node_i,
  input  logic [NUM_WAY-1:0] access_way_i,
  output logic [NUM_WAY-1:0] victim_way_o,
  output logic [NUM_WAY-2:0] node_o
);

  localparam int LVL = $clog2(NUM_WAY);

  // Victim walk, a 0 bit goes left and a 1 bit goes right
  always_comb begin
    int n;
    n = 0;
    for (int l = 0; l < LVL; l++) begin
      n = 2 * n + 1 + int'(node_i[n]);
    end
    victim_way_o = '0;
    // Leaves are numbered after the NUM_WAY-1 inner nodes
    victim_way_o[n - (NUM_WAY - 1)] = 1'b1;
  end

  // Point every node on the accessed path away from that way
  always_comb begin
    int   way;
    int   n;
    logic dir;
    way = 0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (access_way_i[w]) way = w;
    end
    node_o = node_i;
    n      = 0;
    // Way index bits pick the branch, MSB at the root
    for (int l = LVL - 1; l >= 0; l--) begin
      dir       = way[l];
      node_o[n] = ~dir;
      n         = 2 * n + 1 + int'(dir);
    end
  end

endmodule

`default_nettype wire

// ==== hw/sp_bram.sv ====
/* Single-port block RAM with a registered read, write-first on a write.
   Holds the tag, data and replacement-tree arrays of the cache. */
`timescale 1ns/10ps
`default_nettype none

module sp_bram #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 16
) (
  input  logic                     clk_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     wr_en_i,
  input  logic [DATA_W-1:0]        wr_data_i,
  output logic [DATA_W-1:0]        rd_data_o
);

  logic [DATA_W-1:0] mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr_i] <= wr_data_i;
      // New data shows on the read port right away
      rd_data_o     <= wr_data_i;
    end else begin
      rd_data_o     <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
/* Struct types for the CPU lookup port and the refill link of the instruction cache.
   Imported by the RTL, the testbench and the checker. */
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // Lookup from the fetch stage
  typedef struct packed {
    logic                    valid;
    logic [`ICACHE_XLEN-1:0] addr;
  } cpu_req_t;

  // Lookup result, one word at the request address
  typedef struct packed {
    logic                    valid;
    logic                    miss;
    logic [`ICACHE_XLEN-1:0] data;
  } cpu_res_t;

  // Refill request, addr is block aligned
  typedef struct packed {
    logic                    valid;
    logic [`ICACHE_XLEN-1:0] addr;
  } mem_req_t;

  // Refill response carrying the whole block
  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_BLK_BITS-1:0] blk;
  } mem_res_t;

endpackage

`default_nettype wire

// ==== include/icache_macros.svh ====
/* Geometry of the instruction cache and depth of its memory-side link FIFOs.
   Included by the package and by any module that sizes itself from these values. */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Address and data word width
`define ICACHE_XLEN 32

// Cache block in bits, one refill moves a whole block
`define ICACHE_BLK_BITS 128

// Total capacity and associativity
`define ICACHE_SIZE_BYTES 1024
`define ICACHE_NUM_WAY 4

// Entries per link FIFO, also the credits on each link
`define ICACHE_FIFO_DEPTH 2

// Derived geometry
`define ICACHE_NUM_SET ((`ICACHE_SIZE_BYTES * 8 / `ICACHE_BLK_BITS) / `ICACHE_NUM_WAY)
`define ICACHE_IDX_W ($clog2(`ICACHE_NUM_SET))
`define ICACHE_BOFF_W ($clog2(`ICACHE_BLK_BITS / 8))
`define ICACHE_TAG_W (`ICACHE_XLEN - `ICACHE_IDX_W - `ICACHE_BOFF_W)

`endif
